// File: design/decode_stage.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module decode_stage (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  fetch_pkg::if_insn_t  insn_i,
	input  logic                 dec_ready_i,
	output fetch_pkg::dec_rec_t  dec_o,
	output logic                 dec_valid_o,
	output logic                 freeze_o,
	output fetch_pkg::redirect_t redirect_o
);
	import fetch_pkg::*;

	// Decode register
	logic        valid_q;
	dec_rec_t    rec_q;
	logic        load;
	// Jump detect
	logic        is_jump;
	logic [31:0] jump_tgt;
	// Exception vector for the incoming record
	logic [31:0] exc_vec;
	// One-cycle redirect
	logic        redir_valid_q;
	logic [31:0] redir_tgt_q;

	// Output held and not taken
	assign freeze_o = valid_q & ~dec_ready_i;

	// Drop anything arriving in the redirect cycle
	assign load = insn_i.valid & ~freeze_o & ~redir_valid_q;

	////////////////////
	// Decode
	////////////////////

	assign is_jump = (insn_i.exc == EXC_NONE) &&
		(insn_i.insn[31:26] == `FETCH_OPC_JUMP);

	// Offset in words, sign extended
	assign jump_tgt = insn_i.pc + {{4{insn_i.insn[25]}}, insn_i.insn[25:0], 2'b00};

	always_comb begin
		case (insn_i.exc)
			EXC_ITLB:   exc_vec = `FETCH_VEC_ITLB;
			EXC_IMMU:   exc_vec = `FETCH_VEC_IMMU;
			EXC_BUSERR: exc_vec = `FETCH_VEC_BUSERR;
			default:    exc_vec = 32'h0;
		endcase
	end

	////////////////////
	// Registers
	////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q       <= 1'b0;
			redir_valid_q <= 1'b0;
		end else begin
			if (load) begin
				valid_q <= 1'b1;
			end else if (dec_ready_i) begin
				valid_q <= 1'b0;
			end
			// Only for one cycle after the load
			redir_valid_q <= load & (is_jump | (insn_i.exc != EXC_NONE));
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			rec_q <= '{pc: insn_i.pc, insn: insn_i.insn, exc: insn_i.exc,
				is_jump: is_jump};
			redir_tgt_q <= is_jump ? jump_tgt : exc_vec;
		end
	end

	////////////////////
	// Outputs
	////////////////////

	assign dec_o       = rec_q;
	assign dec_valid_o = valid_q;
	// Also flushes the fetch stage
	assign redirect_o  = '{valid: redir_valid_q, target: redir_tgt_q};

endmodule

// File: design/fetch_pkg.sv
package fetch_pkg;

	////////////////////
	// Fetch request
	////////////////////

	// Request from PC generator, stale set once a redirect overtakes it
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic        stale;
	} fetch_req_t;

	// Fetch exception kinds
	typedef enum logic [1:0] {
		EXC_NONE   = 2'd0,
		EXC_ITLB   = 2'd1,
		EXC_IMMU   = 2'd2,
		EXC_BUSERR = 2'd3
	} exc_code_t;

	// Fetch stage output toward decode
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] insn;
		exc_code_t   exc;
	} if_insn_t;

	// PC redirect, valid doubles as flush
	typedef struct packed {
		logic        valid;
		logic [31:0] target;
	} redirect_t;

	// Decoded record on the output port
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] insn;
		exc_code_t   exc;
		logic        is_jump;
	} dec_rec_t;

endpackage

// File: design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic                clk,
	input  logic                arst_n_i,
	output logic                icpu_req_o,
	output logic [31:0]         icpu_adr_o,
	input  logic [31:0]         icpu_dat_i,
	input  logic                icpu_ack_i,
	input  logic                icpu_err_i,
	input  logic [3:0]          icpu_tag_i,
	output fetch_pkg::dec_rec_t dec_o,
	output logic                dec_valid_o,
	input  logic                dec_ready_i
);
	import fetch_pkg::*;

	fetch_req_t req;
	if_insn_t   if_insn;
	redirect_t  redirect;
	// Handshake between fetch stage and PC generator
	logic       adv;
	logic       hold;
	// Back-pressure from decode
	logic       freeze;

	////////////////////
	// Producer
	////////////////////

	pc_gen pc_gen_inst (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.adv_i      (adv),
		.hold_i     (hold),
		.redirect_i (redirect),
		.req_o      (req)
	);

	// Cache port request
	assign icpu_req_o = req.valid;
	assign icpu_adr_o = req.addr;

	////////////////////
	// Buffer
	////////////////////

	if_stage if_stage_inst (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.req_i      (req),
		.icpu_dat_i (icpu_dat_i),
		.icpu_ack_i (icpu_ack_i),
		.icpu_err_i (icpu_err_i),
		.icpu_tag_i (icpu_tag_i),
		.freeze_i   (freeze),
		.flush_i    (redirect.valid),
		.insn_o     (if_insn),
		.adv_o      (adv),
		.hold_o     (hold)
	);

	// Consumer
	decode_stage decode_stage_inst (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.insn_i      (if_insn),
		.dec_ready_i (dec_ready_i),
		.dec_o       (dec_o),
		.dec_valid_o (dec_valid_o),
		.freeze_o    (freeze),
		.redirect_o  (redirect)
	);

endmodule

// File: design/if_stage.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module if_stage (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  fetch_pkg::fetch_req_t req_i,
	input  logic [31:0]           icpu_dat_i,
	input  logic                  icpu_ack_i,
	input  logic                  icpu_err_i,
	input  logic [3:0]            icpu_tag_i,
	input  logic                  freeze_i,
	input  logic                  flush_i,
	output fetch_pkg::if_insn_t   insn_o,
	output logic                  adv_o,
	output logic                  hold_o
);
	import fetch_pkg::*;

	// Response for the request in progress
	logic        resp;
	// Response that may go on to decode
	logic        live_ok;
	logic [31:0] live_insn;
	exc_code_t   live_exc;
	// Save slot
	logic        save_now;
	logic        saved_q;
	logic        saved_d;
	logic [31:0] pc_saved_q;
	logic [31:0] insn_saved_q;
	exc_code_t   exc_saved_q;

	assign resp = req_i.valid & (icpu_ack_i | icpu_err_i);
	// Stale answers and flushed cycles are swallowed
	assign live_ok = resp & ~req_i.stale & ~flush_i;

	////////////////////
	// Error tag mapping
	////////////////////

	always_comb begin
		live_exc = EXC_NONE;
		if (icpu_err_i) begin
			case (icpu_tag_i)
				`FETCH_TAG_TE: live_exc = EXC_ITLB;
				`FETCH_TAG_PE: live_exc = EXC_IMMU;
				`FETCH_TAG_BE: live_exc = EXC_BUSERR;
				// Unknown tag treated as bus error
				default:       live_exc = EXC_BUSERR;
			endcase
		end
	end

	// Failed fetch carries a NOP
	assign live_insn = icpu_err_i ? `FETCH_NOP_INSN : icpu_dat_i;

	////////////////////
	// Save slot
	////////////////////

	// Only one entry, the frozen pipe stops further requests
	assign save_now = live_ok & freeze_i & ~saved_q;

	always_comb begin
		saved_d = saved_q;
		if (flush_i) begin
			saved_d = 1'b0;
		end else if (save_now) begin
			saved_d = 1'b1;
		end else if (!freeze_i) begin
			// Replayed this cycle
			saved_d = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			saved_q <= 1'b0;
		end else begin
			saved_q <= saved_d;
		end
	end

	always_ff @(posedge clk) begin
		if (save_now) begin
			pc_saved_q   <= req_i.addr;
			insn_saved_q <= live_insn;
			exc_saved_q  <= live_exc;
		end
	end

	////////////////////
	// Output select
	////////////////////

	always_comb begin
		if (saved_q) begin
			// Replay in the first unfrozen cycle
			insn_o = '{valid: ~freeze_i & ~flush_i, pc: pc_saved_q,
				insn: insn_saved_q, exc: exc_saved_q};
		end else begin
			insn_o = '{valid: live_ok & ~freeze_i, pc: req_i.addr,
				insn: live_insn, exc: live_exc};
		end
	end

	// Every response is consumed, so the PC may move on
	assign adv_o  = resp;
	// Keep requests off while an entry sits in the slot
	assign hold_o = saved_d;

endmodule

// File: design/pc_gen.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module pc_gen (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  adv_i,
	input  logic                  hold_i,
	input  fetch_pkg::redirect_t  redirect_i,
	output fetch_pkg::fetch_req_t req_o
);

	// Current fetch address
	logic [31:0] pc_q;
	logic [31:0] pc_d;
	// Redirect target parked until the stale response returns
	logic [31:0] tgt_q;
	// Request in progress
	logic        busy_q;
	// Outstanding request overtaken by a redirect
	logic        stale_q;

	////////////////////
	// Next PC
	////////////////////

	always_comb begin
		pc_d = pc_q;
		// Address may only move when no request is waiting
		if (redirect_i.valid && (adv_i || !busy_q)) begin
			pc_d = redirect_i.target;
		end else if (adv_i) begin
			// Stale response consumed, go to the parked target
			pc_d = stale_q ? tgt_q : pc_q + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q    <= `FETCH_RESET_PC;
			busy_q  <= 1'b0;
			stale_q <= 1'b0;
		end else begin
			pc_q <= pc_d;
			// New request right after a response, unless a save blocks it
			if (!busy_q || adv_i) begin
				busy_q <= ~hold_i;
			end
			if (adv_i) begin
				stale_q <= 1'b0;
			end else if (busy_q && redirect_i.valid) begin
				stale_q <= 1'b1;
			end
		end
	end

	// Target held while the overtaken request finishes
	always_ff @(posedge clk) begin
		if (busy_q && !adv_i && redirect_i.valid) begin
			tgt_q <= redirect_i.target;
		end
	end

	////////////////////
	// Request out
	////////////////////

	assign req_o = '{valid: busy_q, addr: pc_q, stale: stale_q};

endmodule

// File: include/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

////////////////////
// Program counter
////////////////////

// First fetch address after reset
`define FETCH_RESET_PC   32'h0000_0100

// Exception vectors
`define FETCH_VEC_BUSERR 32'h0000_0200
`define FETCH_VEC_IMMU   32'h0000_0400
`define FETCH_VEC_ITLB   32'h0000_0A00

////////////////////
// Cache error tags
////////////////////

`define FETCH_TAG_TE     4'hD
`define FETCH_TAG_PE     4'hC
`define FETCH_TAG_BE     4'hB

// l.nop, used for flushed and failed fetches
`define FETCH_NOP_INSN   32'h1500_0000

// Major opcode of l.j, target is own PC plus sign-extended offset times four
`define FETCH_OPC_JUMP   6'h00

`endif

// File: testbench/fetch_assert.sv
`timescale 1ns/1ps

module fetch_assert (
	input logic                clk,
	input logic                arst_n_i,
	input logic                icpu_req_i,
	input logic [31:0]         icpu_adr_i,
	input logic                icpu_ack_i,
	input logic                icpu_err_i,
	input fetch_pkg::dec_rec_t dec_i,
	input logic                dec_valid_i,
	input logic                dec_ready_i
);

	// Failures seen, read back by the testbench
	int unsigned fail_cnt = 0;

	////////////////////
	// Cache port
	////////////////////

	// Request and address held until ack or err
	req_stable_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		icpu_req_i && !(icpu_ack_i || icpu_err_i) |=> icpu_req_i && $stable(icpu_adr_i))
	else begin
		$error("cache request dropped or address moved before ack/err");
		fail_cnt++;
	end

	// One kind of answer per cycle
	ack_err_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(icpu_ack_i && icpu_err_i))
	else begin
		$error("ack and err high together");
		fail_cnt++;
	end

	////////////////////
	// Output port
	////////////////////

	// Record frozen under back-pressure
	out_stable_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		dec_valid_i && !dec_ready_i |=> dec_valid_i && $stable(dec_i))
	else begin
		$error("output record changed while held");
		fail_cnt++;
	end

	// Nothing valid in reset
	rst_valid_a: assert property (@(posedge clk) !arst_n_i |-> !dec_valid_i)
	else begin
		$error("dec_valid_o high during reset");
		fail_cnt++;
	end

endmodule

bind fetch_unit fetch_assert fetch_assert_inst (
	.clk         (clk),
	.arst_n_i    (arst_n_i),
	.icpu_req_i  (icpu_req_o),
	.icpu_adr_i  (icpu_adr_o),
	.icpu_ack_i  (icpu_ack_i),
	.icpu_err_i  (icpu_err_i),
	.dec_i       (dec_o),
	.dec_valid_i (dec_valid_o),
	.dec_ready_i (dec_ready_i)
);

// File: testbench/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_tb;
	import fetch_pkg::*;

	// Records in the reference walk, 40 cycles allowed for each
	localparam int N_REC      = 320;
	localparam int MAX_CYCLES = 40 * N_REC;

	logic        clk;
	logic        arst_n;
	logic        icpu_req;
	logic [31:0] icpu_adr;
	logic [31:0] icpu_dat;
	logic        icpu_ack;
	logic        icpu_err;
	logic [3:0]  icpu_tag;
	dec_rec_t    dec;
	logic        dec_valid;
	logic        dec_ready;

	// Cache image, fault table, reference stream
	logic [31:0] mem [0:1023];
	logic [31:0] fault_adr [0:2];
	logic [3:0]  fault_tag [0:2];
	dec_rec_t    exp_q [$];

	integer seed      = 97;
	int     cycles    = 0;
	int     n_checked = 0;
	int     errors    = 0;
	// Cache latency countdown, ready-low run
	logic   pending   = 1'b0;
	int     wait_cnt  = 0;
	int     stall_cnt = 0;

	tb_clock_gen tb_clock_gen_inst (.clk_o(clk), .arst_n_o(arst_n));

	fetch_unit fetch_unit_inst (
		.clk         (clk),
		.arst_n_i    (arst_n),
		.icpu_req_o  (icpu_req),
		.icpu_adr_o  (icpu_adr),
		.icpu_dat_i  (icpu_dat),
		.icpu_ack_i  (icpu_ack),
		.icpu_err_i  (icpu_err),
		.icpu_tag_i  (icpu_tag),
		.dec_o       (dec),
		.dec_valid_o (dec_valid),
		.dec_ready_i (dec_ready)
	);

	// l.j at pc landing on tgt
	task automatic place_jump(input logic [31:0] pc, input logic [31:0] tgt);
		logic [31:0] diff;
		diff = tgt - pc;
		mem[pc[11:2]] = {`FETCH_OPC_JUMP, diff[27:2]};
	endtask

	function automatic bit find_fault(input logic [31:0] adr, output logic [3:0] tag);
		bit hit;
		hit = 1'b0;
		tag = 4'h0;
		for (int i = 0; i < 3; i++) begin
			if (fault_adr[i] == adr) begin
				hit = 1'b1;
				tag = fault_tag[i];
			end
		end
		return hit;
	endfunction

	////////////////////
	// Reference walk
	////////////////////

	// Record for pc, returns where the program goes next
	function automatic logic [31:0] ref_step(input logic [31:0] pc, output dec_rec_t rec);
		logic [3:0]  tag;
		logic [31:0] w;
		logic [31:0] next;
		rec.pc      = pc;
		rec.is_jump = 1'b0;
		if (find_fault(pc, tag)) begin
			rec.insn = `FETCH_NOP_INSN;
			rec.exc  = EXC_BUSERR;
			next     = `FETCH_VEC_BUSERR;
			if (tag == `FETCH_TAG_TE) begin
				rec.exc = EXC_ITLB;
				next    = `FETCH_VEC_ITLB;
			end else if (tag == `FETCH_TAG_PE) begin
				rec.exc = EXC_IMMU;
				next    = `FETCH_VEC_IMMU;
			end
		end else begin
			w        = mem[pc[11:2]];
			rec.insn = w;
			rec.exc  = EXC_NONE;
			next     = pc + 32'd4;
			if (w[31:26] == `FETCH_OPC_JUMP) begin
				rec.is_jump = 1'b1;
				// Word offset, signed
				next = pc + 32'($signed(w[25:0])) * 4;
			end
		end
		return next;
	endfunction

	////////////////////
	// Stimulus
	////////////////////

	// Cache answers and back-pressure, all on the falling edge
	always @(negedge clk) begin
		logic [3:0] ftag;
		icpu_ack <= 1'b0;
		icpu_err <= 1'b0;
		if (icpu_req) begin
			// New request, pick its latency
			if (!pending) begin
				pending  = 1'b1;
				wait_cnt = {$random(seed)} % 5;
			end
			if (wait_cnt == 0) begin
				pending = 1'b0;
				if (find_fault(icpu_adr, ftag)) begin
					icpu_err <= 1'b1;
					icpu_tag <= ftag;
					icpu_dat <= $random(seed);
				end else begin
					icpu_ack <= 1'b1;
					icpu_dat <= mem[icpu_adr[11:2]];
				end
			end else begin
				wait_cnt = wait_cnt - 1;
			end
		end
		if (stall_cnt > 0) begin
			stall_cnt = stall_cnt - 1;
			dec_ready <= 1'b0;
		end else if ({$random(seed)} % 24 == 0) begin
			// Long stall, fills the save slot
			stall_cnt = 6 + {$random(seed)} % 14;
			dec_ready <= 1'b0;
		end else begin
			dec_ready <= ({$random(seed)} % 4) != 0;
		end
	end

	////////////////////
	// Compare
	////////////////////

	always @(posedge clk) begin
		dec_rec_t exp;
		cycles <= cycles + 1;
		if (arst_n && dec_valid && dec_ready) begin
			if (exp_q.size() == 0) begin
				$display("Record at pc %h accepted past the end of the stream", dec.pc);
				errors++;
			end else begin
				exp = exp_q.pop_front();
				if (dec.pc !== exp.pc) begin
					$display("[FAIL] t=%0t dec_o.pc exp %h got %h", $time, exp.pc, dec.pc);
					errors++;
				end
				if (dec.insn !== exp.insn) begin
					$display("[FAIL] t=%0t dec_o.insn exp %h got %h", $time, exp.insn, dec.insn);
					errors++;
				end
				if (dec.exc !== exp.exc) begin
					$display("[FAIL] t=%0t dec_o.exc exp %0d got %0d", $time, exp.exc, dec.exc);
					errors++;
				end
				if (dec.is_jump !== exp.is_jump) begin
					$display("[FAIL] t=%0t dec_o.is_jump exp %0b got %0b", $time,
						exp.is_jump, dec.is_jump);
					errors++;
				end
			end
			n_checked++;
		end
	end

	initial begin
		logic [31:0] pc;
		dec_rec_t    rec;
		int          asrt;
		icpu_dat  = 32'h0;
		icpu_ack  = 1'b0;
		icpu_err  = 1'b0;
		icpu_tag  = 4'h0;
		dec_ready = 1'b0;
		// Random program, no stray jumps
		for (int i = 0; i < 1024; i++) begin
			mem[i] = $random(seed);
			if (mem[i][31:26] == `FETCH_OPC_JUMP) begin
				mem[i][31] = ~mem[i][31];
			end
		end
		// Loop over all three vectors and back to reset PC
		place_jump(32'h110, 32'h11C);
		place_jump(32'h140, 32'h300);
		place_jump(32'hA20, 32'h180);
		place_jump(32'h240, 32'h100);
		fault_adr[0] = 32'h330;
		fault_tag[0] = `FETCH_TAG_TE;
		fault_adr[1] = 32'h1A0;
		fault_tag[1] = `FETCH_TAG_PE;
		fault_adr[2] = 32'h440;
		fault_tag[2] = `FETCH_TAG_BE;
		pc = `FETCH_RESET_PC;
		for (int n = 0; n < N_REC; n++) begin
			pc = ref_step(pc, rec);
			exp_q.push_back(rec);
		end
		while (n_checked < N_REC && cycles < MAX_CYCLES) begin
			@(negedge clk);
		end
		if (n_checked < N_REC) begin
			$display("Timeout after %0d cycles, only %0d of %0d records arrived",
				cycles, n_checked, N_REC);
			errors++;
		end
		asrt = fetch_unit_inst.fetch_assert_inst.fail_cnt;
		$display("Summary: %0d records checked, %0d errors, %0d assertion failures",
			n_checked, errors, asrt);
		if (errors == 0 && asrt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_o,
	output logic arst_n_o
);

	// 8 ns period
	localparam int HALF_NS = 4;

	initial begin
		clk_o    = 1'b0;
		arst_n_o = 1'b1;
		// Reset edge after time zero so every flop sees it
		#1;
		arst_n_o = 1'b0;
		// Two rising edges in reset, release on a falling edge
		#(4 * HALF_NS - 1);
		arst_n_o = 1'b1;
	end

	always #HALF_NS clk_o = ~clk_o;

endmodule

// File: vlog.f
+incdir+include
design/fetch_pkg.sv
design/pc_gen.sv
design/if_stage.sv
design/decode_stage.sv
design/fetch_unit.sv
testbench/tb_clock_gen.sv
testbench/fetch_assert.sv
testbench/fetch_tb.sv
